// ==== hdl/gfx_pkg.sv ====
/* Graphics compositor shared definitions */
package gfx_pkg;

    // Configuration register map
    localparam int reg_count    = 8;
    localparam int reg_scroll_x = 1;
    localparam int reg_layout   = 3;
    localparam int reg_misc     = 6;
    localparam int reg_int      = 7;

    // Layer windows in dump coordinates
    localparam logic [8:0] wide_chr_start = 9'd0;
    localparam logic [8:0] wide_chr_end   = 9'd40;
    localparam logic [8:0] wide_scr_start = 9'd40;
    localparam logic [8:0] wide_scr_end   = 9'd296;
    localparam logic [8:0] flip_chr_start = 9'd240;
    localparam logic [8:0] flip_chr_end   = 9'd296;
    localparam logic [8:0] flip_scr_start = 9'd0;
    localparam logic [8:0] flip_scr_end   = 9'd240;
    localparam logic [8:0] norm_start     = 9'd16;
    localparam logic [8:0] norm_end       = 9'd264;

    // Blank borders
    localparam logic [8:0] narrow_lo    = 9'd24;
    localparam logic [8:0] narrow_hi    = 9'd264;
    localparam logic [8:0] wide_lo      = 9'd16;
    localparam logic [8:0] wide_hi      = 9'd272;
    localparam logic [8:0] vblank_lines = 9'd16;

    typedef struct packed {
        logic       win;
        logic [7:0] color;
    } line_pxl_t;

    typedef struct packed {
        logic       flip;
        logic       layout;
        logic       narrow_en;
        logic       scrwin_en;
        logic       irq_en;
        logic       nmi_en;
        logic [1:0] pal_bank;
        logic [8:0] chr_start;
        logic [8:0] chr_end;
        logic [8:0] scr_start;
        logic [8:0] scr_end;
    } cfg_t;

    typedef struct packed {
        logic       cs;
        logic       rnw;
        logic       cen;
        logic [2:0] addr;
        logic [7:0] data;
    } cpu_bus_t;

    typedef struct packed {
        logic       we;
        logic [8:0] addr;
        logic [3:0] data;
    } prom_prog_t;

    typedef struct packed {
        logic [3:0] color;
        logic       blank;
        logic       scr_prio;
        logic       chr_area;
    } layer_pxl_t;

endpackage

// ==== hdl/gfx_regs.sv ====
/* Configuration registers */
`timescale 1ns/1ps

module gfx_regs (
    input  logic            clk,
    input  logic            rst,
    input  gfx_pkg::cpu_bus_t bus,
    output logic [7:0]      dout,
    output gfx_pkg::cfg_t   cfg
);

    logic [7:0] mmr [gfx_pkg::reg_count];
    logic       wr_en;
    logic [8:0] chr_start;
    logic [8:0] chr_end;
    logic [8:0] scr_start;
    logic [8:0] scr_end;

    assign wr_en = bus.cen & bus.cs & ~bus.rnw;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < gfx_pkg::reg_count; i++) begin
                mmr[i] <= 8'd0;
            end
        end else if (wr_en) begin
            mmr[bus.addr] <= bus.data;
        end
    end

    // CPU read-back
    assign dout = mmr[bus.addr];

    // Window bounds follow layout and flip on bus strobe cycles
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            chr_start <= gfx_pkg::norm_start;
            chr_end   <= gfx_pkg::norm_end;
            scr_start <= gfx_pkg::norm_start;
            scr_end   <= gfx_pkg::norm_end;
        end else if (bus.cen) begin
            if (cfg.layout) begin
                if (cfg.flip) begin
                    chr_start <= gfx_pkg::flip_chr_start;
                    chr_end   <= gfx_pkg::flip_chr_end;
                    scr_start <= gfx_pkg::flip_scr_start;
                    scr_end   <= gfx_pkg::flip_scr_end;
                end else begin
                    chr_start <= gfx_pkg::wide_chr_start;
                    chr_end   <= gfx_pkg::wide_chr_end;
                    scr_start <= gfx_pkg::wide_scr_start;
                    scr_end   <= gfx_pkg::wide_scr_end;
                end
            end else begin
                // Both layers share the 248 visible pixels
                chr_start <= gfx_pkg::norm_start;
                chr_end   <= gfx_pkg::norm_end;
                scr_start <= gfx_pkg::norm_start;
                scr_end   <= gfx_pkg::norm_end;
            end
        end
    end

    // Field decode
    always_comb begin
        cfg.layout    = mmr[gfx_pkg::reg_layout][4];
        cfg.narrow_en = mmr[gfx_pkg::reg_layout][6];
        cfg.scrwin_en = mmr[gfx_pkg::reg_misc][3];
        cfg.pal_bank  = mmr[gfx_pkg::reg_misc][5:4];
        cfg.nmi_en    = mmr[gfx_pkg::reg_int][0];
        cfg.irq_en    = mmr[gfx_pkg::reg_int][1];
        cfg.flip      = mmr[gfx_pkg::reg_int][3];
        cfg.chr_start = chr_start;
        cfg.chr_end   = chr_end;
        cfg.scr_start = scr_start;
        cfg.scr_end   = scr_end;
    end

endmodule

// ==== hdl/gfx_irq.sv ====
/* Frame IRQ and NMI generator */
`timescale 1ns/1ps

module gfx_irq (
    input  logic          clk,
    input  logic          rst,
    input  logic          pxl_cen,
    input  logic          lvbl,
    input  logic          lhbl,
    input  logic [8:0]    vdump,
    input  gfx_pkg::cfg_t cfg,
    output logic          cpu_irqn,
    output logic          cpu_nmin
);

    logic last_lvbl;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_lvbl <= 1'b0;
            cpu_irqn  <= 1'b1;
            cpu_nmin  <= 1'b1;
        end else if (pxl_cen) begin
            last_lvbl <= lvbl;
            // Start of vertical blank
            if (!lvbl && last_lvbl) begin
                if (cfg.irq_en) cpu_irqn <= 1'b0;
            end else if (lhbl || !cfg.irq_en) begin
                cpu_irqn <= 1'b1;
            end
            // Once every 64 lines and held while bits 5:4 stay set
            if (!cfg.nmi_en || vdump[5:4] != 2'b11) begin
                cpu_nmin <= 1'b1;
            end else if (vdump[5:0] == 6'b11_0000) begin
                cpu_nmin <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/tile_layer.sv ====
/* Character and scroll layer path */
`timescale 1ns/1ps

module tile_layer (
    input  logic                clk,
    input  logic                rst,
    input  logic [8:0]          hdump,
    input  gfx_pkg::line_pxl_t  chr_pxl,
    input  gfx_pkg::line_pxl_t  scr_pxl,
    input  gfx_pkg::cfg_t       cfg,
    input  gfx_pkg::prom_prog_t prog,
    output gfx_pkg::layer_pxl_t tile
);

    logic [3:0] prom [256];
    logic       chr_area;
    logic       scr_area;
    logic       draw_scr;
    logic [7:0] pal_addr;
    logic [3:0] pal_data;
    logic [1:0] prio_d;
    logic [1:0] area_d;

    assign chr_area = hdump >= cfg.chr_start && hdump < cfg.chr_end;
    assign scr_area = hdump >= cfg.scr_start && hdump < cfg.scr_end;

    // Window decides first, then character transparency
    always_comb begin
        if (chr_area && !scr_area) begin
            draw_scr = 1'b0;
        end else if (!chr_area && scr_area) begin
            draw_scr = 1'b1;
        end else begin
            draw_scr = chr_pxl.color[3:0] == 4'h0;
        end
    end

    // Tile PROM sits in the upper half of the programming space
    always_ff @(posedge clk) begin
        if (prog.we && prog.addr[8]) begin
            prom[prog.addr[7:0]] <= prog.data;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pal_addr <= 8'd0;
            pal_data <= 4'd0;
            prio_d   <= 2'b00;
            area_d   <= 2'b00;
        end else begin
            pal_addr <= draw_scr ? scr_pxl.color : chr_pxl.color;
            pal_data <= prom[pal_addr];
            prio_d   <= {prio_d[0], cfg.scrwin_en & scr_pxl.win};
            area_d   <= {area_d[0], chr_area};
        end
    end

    assign tile.color    = pal_data;
    assign tile.blank    = pal_data == 4'h0;
    assign tile.scr_prio = prio_d[1];
    assign tile.chr_area = area_d[1];

endmodule

// ==== hdl/obj_layer.sv ====
/* Object palette path */
`timescale 1ns/1ps

module obj_layer (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          obj_pxl,
    input  gfx_pkg::prom_prog_t prog,
    output gfx_pkg::layer_pxl_t obj
);

    logic [3:0] prom [256];
    logic [7:0] pal_addr;
    logic [3:0] pal_data;

    // Object PROM is the lower half
    always_ff @(posedge clk) begin
        if (prog.we && !prog.addr[8]) begin
            prom[prog.addr[7:0]] <= prog.data;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pal_addr <= 8'd0;
            pal_data <= 4'd0;
        end else begin
            pal_addr <= obj_pxl;
            pal_data <= prom[pal_addr];
        end
    end

    assign obj.color    = pal_data;
    assign obj.blank    = pal_data == 4'h0;
    assign obj.scr_prio = 1'b0;
    assign obj.chr_area = 1'b0;

endmodule

// ==== hdl/pxl_mixer.sv ====
/* Layer priority mixer */
`timescale 1ns/1ps

module pxl_mixer (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  logic [8:0]          hdump,
    input  logic [8:0]          vdump,
    input  gfx_pkg::layer_pxl_t tile,
    input  gfx_pkg::layer_pxl_t obj,
    input  gfx_pkg::cfg_t       cfg,
    output logic [6:0]          pxl_out
);

    logic       border_narrow;
    logic       border_wide;
    logic       blank_area;
    logic [1:0] blank_d;
    logic       tile_wins;

    assign border_narrow = cfg.narrow_en &&
                           (hdump < gfx_pkg::narrow_lo || hdump >= gfx_pkg::narrow_hi);
    assign border_wide   = hdump < gfx_pkg::wide_lo || hdump >= gfx_pkg::wide_hi;
    assign blank_area    = vdump < gfx_pkg::vblank_lines ||
                           (!cfg.layout && (border_narrow || border_wide));

    // Object shows only where the tile does not claim the pixel
    assign tile_wins = obj.blank || (cfg.layout && tile.chr_area) ||
                       (tile.scr_prio && !tile.blank);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            blank_d <= 2'b00;
            pxl_out <= '1;
        end else begin
            // Aligned with the two-stage layer pipelines
            blank_d <= {blank_d[0], blank_area};
            if (pxl_cen) begin
                if (blank_d[1]) begin
                    pxl_out <= 7'd0;
                end else if (tile_wins) begin
                    pxl_out <= {cfg.pal_bank, 1'b1, tile.color};
                end else begin
                    pxl_out <= {cfg.pal_bank, 1'b0, obj.color};
                end
            end
        end
    end

endmodule

// ==== hdl/gfx_top.sv ====
/* Pixel compositor top level */
`timescale 1ns/1ps

module gfx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                pxl_cen,
    input  logic                lhbl,
    input  logic                lvbl,
    input  logic [8:0]          hdump,
    input  logic [8:0]          vdump,
    input  gfx_pkg::line_pxl_t  chr_pxl,
    input  gfx_pkg::line_pxl_t  scr_pxl,
    input  logic [7:0]          obj_pxl,
    input  gfx_pkg::cpu_bus_t   bus,
    input  gfx_pkg::prom_prog_t prog,
    output logic [7:0]          dout,
    output logic                cpu_irqn,
    output logic                cpu_nmin,
    output logic                flip,
    output logic [6:0]          pxl_out
);

    gfx_pkg::cfg_t       cfg;
    gfx_pkg::layer_pxl_t tile;
    gfx_pkg::layer_pxl_t obj;

    assign flip = cfg.flip;

    gfx_regs regs_i (
        .clk  (clk),
        .rst  (rst),
        .bus  (bus),
        .dout (dout),
        .cfg  (cfg)
    );

    gfx_irq irq_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lvbl     (lvbl),
        .lhbl     (lhbl),
        .vdump    (vdump),
        .cfg      (cfg),
        .cpu_irqn (cpu_irqn),
        .cpu_nmin (cpu_nmin)
    );

    tile_layer tile_i (
        .clk     (clk),
        .rst     (rst),
        .hdump   (hdump),
        .chr_pxl (chr_pxl),
        .scr_pxl (scr_pxl),
        .cfg     (cfg),
        .prog    (prog),
        .tile    (tile)
    );

    obj_layer obj_i (
        .clk     (clk),
        .rst     (rst),
        .obj_pxl (obj_pxl),
        .prog    (prog),
        .obj     (obj)
    );

    pxl_mixer mixer_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .tile    (tile),
        .obj     (obj),
        .cfg     (cfg),
        .pxl_out (pxl_out)
    );

endmodule

// ==== verif/tb_gfx.sv ====
/* Pixel compositor testbench */
`timescale 1ns/1ps

module tb_gfx;

    logic                clk;
    logic                rst;
    logic                pxl_cen;
    logic                lhbl;
    logic                lvbl;
    logic [8:0]          hdump;
    logic [8:0]          vdump;
    gfx_pkg::line_pxl_t  chr_pxl;
    gfx_pkg::line_pxl_t  scr_pxl;
    logic [7:0]          obj_pxl;
    gfx_pkg::cpu_bus_t   bus;
    gfx_pkg::prom_prog_t prog;
    logic [7:0]          dout;
    logic                cpu_irqn;
    logic                cpu_nmin;
    logic                flip;
    logic [6:0]          pxl_out;

    logic [31:0] rng;
    logic [7:0]  regs [8];
    logic [3:0]  tile_rom [256];
    logic [3:0]  obj_rom [256];
    logic [8:0]  edges [13];
    logic        quiet;

    gfx_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Interrupts stay idle while both enables are clear
    assert property (@(posedge clk) disable iff (rst) quiet |-> cpu_irqn && cpu_nmin)
        else report_failure("interrupt asserted with both enables clear");

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_failure(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        bus = '{cs: 1'b1, rnw: 1'b0, cen: 1'b1, addr: addr, data: data};
        tick(1);
        bus.cs  = 1'b0;
        bus.rnw = 1'b1;
        regs[addr] = data;
        tick(1);
    endtask

    task automatic check_read(input int a, input logic [7:0] want);
        bus.addr = 3'(a);
        tick(1);
        assert (dout == want)
            else report_failure($sformatf("register %0d read %h, expected %h", a, dout, want));
    endtask

    task automatic wait_irq(input logic nmi, input logic level);
        int n;
        n = 0;
        while ((nmi ? cpu_nmin : cpu_irqn) != level) begin
            if (n == 10) begin
                $display("SOME TESTS FAILED");
                $fatal(1, "Interrupt output did not reach the expected level in 10 cycles");
            end else begin
                tick(1);
                n++;
            end
        end
    endtask

    // Expected pixel from the layer window, priority and border rules
    function automatic logic [6:0] ref_pxl(input logic [8:0] h, input logic [8:0] v,
                                           input logic [7:0] c, input logic [8:0] s,
                                           input logic [7:0] o);
        logic       wide;
        logic       ca;
        logic       sa;
        logic       blank;
        logic [3:0] t;
        wide = regs[3][4];
        if (!wide) begin
            ca = h >= 9'd16 && h < 9'd264;
            sa = ca;
        end else if (regs[7][3]) begin
            ca = h >= 9'd240 && h < 9'd296;
            sa = h < 9'd240;
        end else begin
            ca = h < 9'd40;
            sa = h >= 9'd40 && h < 9'd296;
        end
        // Transparent character falls through to scroll when the windows agree
        if (ca == sa) sa = c[3:0] == 4'h0;
        t = sa ? tile_rom[s[7:0]] : tile_rom[c];
        blank = v < 9'd16 || (!wide && ((regs[3][6] && (h < 9'd24 || h >= 9'd264)) ||
                                         h < 9'd16 || h >= 9'd272));
        if (blank) return 7'd0;
        if (obj_rom[o] == 4'h0 || (wide && ca) || (regs[6][3] && s[8] && t != 4'h0))
            return {regs[6][5:4], 1'b1, t};
        return {regs[6][5:4], 1'b0, obj_rom[o]};
    endfunction

    task automatic check_pxl(input logic [8:0] h, input logic [8:0] v, input logic [7:0] c,
                             input logic [8:0] s, input logic [7:0] o);
        logic [6:0] want;
        hdump   = h;
        vdump   = v;
        chr_pxl = '{win: 1'b0, color: c};
        scr_pxl = s;
        obj_pxl = o;
        want    = ref_pxl(h, v, c, s, o);
        tick(4);
        assert (pxl_out == want)
            else report_failure($sformatf("pxl_out %h, expected %h at h=%0d v=%0d",
                                          pxl_out, want, h, v));
    endtask

    initial begin
        logic [31:0] r;
        logic [7:0]  c;
        rng     = 32'd56971;
        quiet   = 1'b0;
        rst     = 1'b1;
        pxl_cen = 1'b1;
        lhbl    = 1'b0;
        lvbl    = 1'b1;
        hdump   = 9'd0;
        vdump   = 9'd0;
        chr_pxl = '0;
        scr_pxl = '0;
        obj_pxl = 8'd0;
        bus     = '{cs: 1'b0, rnw: 1'b1, cen: 1'b1, addr: 3'd0, data: 8'd0};
        prog    = '0;
        edges   = '{9'd0, 9'd15, 9'd16, 9'd23, 9'd24, 9'd39, 9'd40,
                    9'd263, 9'd264, 9'd271, 9'd272, 9'd300, 9'd100};
        tick(3);
        rst = 1'b0;
        assert (cpu_irqn && cpu_nmin && pxl_out == 7'h7f && !flip)
            else report_failure("outputs not idle after reset");

        // Register reset values and read-back
        for (int a = 0; a < 8; a++) begin
            check_read(a, 8'd0);
        end
        for (int a = 0; a < 8; a++) begin
            write_reg(3'(a), 8'(xorshift()));
        end
        for (int a = 0; a < 8; a++) begin
            check_read(a, regs[a]);
        end

        // Only object entry 0 is blank and odd tile entries never are
        for (int a = 0; a < 256; a++) begin
            r = xorshift();
            tile_rom[a] = r[3:0] | {3'b000, a[0]};
            obj_rom[a]  = a == 0 ? 4'h0 : (r[7:4] == 4'h0 ? 4'h9 : r[7:4]);
            prog = '{we: 1'b1, addr: {1'b1, 8'(a)}, data: tile_rom[a]};
            tick(1);
            prog = '{we: 1'b1, addr: {1'b0, 8'(a)}, data: obj_rom[a]};
            tick(1);
        end
        prog.we = 1'b0;

        // Frame IRQ, then line NMI, then both disabled
        write_reg(3'd7, 8'h02);
        lvbl = 1'b0;
        wait_irq(1'b0, 1'b0);
        tick(2);
        assert (!cpu_irqn)
            else report_failure("IRQ released before LHBL went high");
        lhbl = 1'b1;
        wait_irq(1'b0, 1'b1);
        lhbl = 1'b0;
        lvbl = 1'b1;
        write_reg(3'd7, 8'h01);
        vdump = 9'd48;
        wait_irq(1'b1, 1'b0);
        vdump = 9'd0;
        wait_irq(1'b1, 1'b1);
        write_reg(3'd7, 8'h00);
        quiet = 1'b1;
        lvbl  = 1'b0;
        vdump = 9'd48;
        tick(4);
        lvbl  = 1'b1;
        vdump = 9'd0;
        tick(2);
        quiet = 1'b0;

        // Normal layout selection with a blank object
        write_reg(3'd3, 8'h00);
        write_reg(3'd6, {2'b00, 2'b01, 4'h0});
        for (int k = 0; k < 16; k++) begin
            r = xorshift();
            c = k[0] ? {r[7:4], 4'h0} : r[7:0] | 8'h01;
            check_pxl(9'd16 + {1'b0, r[15:8]} % 9'd248, 9'd16 + {1'b0, r[23:16]}, c,
                      9'(xorshift()), 8'd0);
        end

        // Object against tile, then scroll window priority
        for (int k = 0; k < 16; k++) begin
            if (k == 8) write_reg(3'd6, {2'b00, 2'b10, 4'h8});
            r = xorshift();
            check_pxl(9'd16 + {1'b0, r[15:8]} % 9'd248, 9'd100, {r[7:4], 4'h0},
                      {r[24], r[23:16] | 8'h01}, r[31:24] | 8'h01);
        end

        // Borders in plain, narrow, wide and flipped wide layouts
        for (int w = 0; w < 4; w++) begin
            if (w == 1) write_reg(3'd3, 8'h40);
            if (w == 2) write_reg(3'd3, 8'h50);
            if (w == 3) write_reg(3'd7, 8'h08);
            for (int k = 0; k < 13; k++) begin
                r = xorshift();
                check_pxl(edges[k], k == 12 ? {5'd0, r[19:16]} : 9'd100, r[7:0],
                          9'(xorshift()), r[15:8] | 8'h01);
            end
        end
        assert (flip) else report_failure("flip output not set");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/gfx_pkg.sv
hdl/gfx_regs.sv
hdl/gfx_irq.sv
hdl/tile_layer.sv
hdl/obj_layer.sv
hdl/pxl_mixer.sv
hdl/gfx_top.sv
verif/tb_gfx.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_gfx -f vlog.f -o tb_gfx_sim \
    && ./obj_dir/tb_gfx_sim \
    || exit 1
